/* hw/ntm_divider_pkg.sv */
/*
 * Shared definitions for the vector modular divider
 * Sizes, lane count and data constants
 * Job and result structs, result status enum
 */

package ntm_divider_pkg;

  ////////////////////
  // Sizes
  ////////////////////

  // Modulus, operands and quotient
  localparam int DATA_SIZE = 32;

  // Lanes working in parallel
  localparam int NUM_LANES = 4;

  // Job tag, returned with the result
  localparam int TAG_SIZE = 4;

  // Lane index, NUM_LANES is 2**LANE_SIZE
  localparam int LANE_SIZE = 2;

  // Data constants
  localparam logic [DATA_SIZE-1:0] ZERO_DATA   = '0;
  localparam logic [DATA_SIZE-1:0] ONE_DATA    = 1;
  localparam logic [DATA_SIZE-1:0] MIN_MODULUS = 3;

  ////////////////////
  // Types
  ////////////////////

  // Result status
  typedef enum logic [1:0] {
    ok,
    no_inverse,
    bad_modulus,
    bad_operand
  } div_status_t;

  // One job, 100 bits
  typedef struct packed {
    logic [TAG_SIZE-1:0]  tag;
    logic [DATA_SIZE-1:0] modulus;
    logic [DATA_SIZE-1:0] dividend;
    logic [DATA_SIZE-1:0] divisor;
  } div_job_t;

  // One result, 38 bits
  typedef struct packed {
    logic [TAG_SIZE-1:0]  tag;
    logic [DATA_SIZE-1:0] quotient;
    div_status_t          status;
  } div_result_t;

endpackage

/* hw/ntm_scalar_modular_divider.sv */
/*
 * Scalar modular divider lane
 * Binary modular inverse method, one step per clock
 * Start/idle on the dispatch side, done/take on the collect side
 */

`timescale 1ns/1ns

module ntm_scalar_modular_divider
  import ntm_divider_pkg::*;
(
  input  logic        CLK,
  input  logic        RST,
  input  logic        start,
  input  div_job_t    job,
  input  logic        take,
  output logic        idle,
  output logic        done,
  output div_result_t result
);

  ////////////////////
  // Signals
  ////////////////////

  // Lane FSM
  enum logic [1:0] {S_IDLE, S_RUN, S_DONE} state;

  // Working registers
  logic [DATA_SIZE-1:0] m_reg;
  logic [DATA_SIZE-1:0] u;
  logic [DATA_SIZE-1:0] v;
  logic [DATA_SIZE-1:0] x;
  logic [DATA_SIZE-1:0] y;

  // Step arithmetic
  logic [DATA_SIZE:0]   x_sum;
  logic [DATA_SIZE:0]   y_sum;
  logic [DATA_SIZE-1:0] x_half;
  logic [DATA_SIZE-1:0] y_half;
  logic [DATA_SIZE-1:0] x_diff;
  logic [DATA_SIZE-1:0] y_diff;

  // Job checks
  logic bad_m;
  logic bad_op;
  logic finish;

  ////////////////////
  // Datapath
  ////////////////////

  // Even modulus or m below 3
  assign bad_m  = !job.modulus[0] || (job.modulus < MIN_MODULUS);
  // Operands not reduced
  assign bad_op = (job.dividend >= job.modulus) || (job.divisor >= job.modulus);

  // Halving mod m, odd values get m added first
  assign x_sum  = {1'b0, x} + {1'b0, m_reg};
  assign y_sum  = {1'b0, y} + {1'b0, m_reg};
  assign x_half = x[0] ? x_sum[DATA_SIZE:1] : (x >> 1);
  assign y_half = y[0] ? y_sum[DATA_SIZE:1] : (y >> 1);

  // Subtraction mod m; wraps back into range when m is added
  assign x_diff = (x >= y) ? (x - y) : (x - y + m_reg);
  assign y_diff = (y >= x) ? (y - x) : (y - x + m_reg);

  // End of the loop: inverse found or gcd not 1
  assign finish = (u == ONE_DATA) || (v == ONE_DATA) ||
                  (u == ZERO_DATA) || (v == ZERO_DATA);

  assign idle = (state == S_IDLE);
  assign done = (state == S_DONE);

  ////////////////////
  // Control
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= S_IDLE;
    end else begin
      case (state)
        S_IDLE: begin
          // Bad jobs skip the loop
          if (start) begin
            state <= (bad_m || bad_op) ? S_DONE : S_RUN;
          end
        end
        S_RUN: begin
          if (finish) begin
            state <= S_DONE;
          end
        end
        S_DONE: begin
          // Hold the result until collected
          if (take) begin
            state <= S_IDLE;
          end
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  ////////////////////
  // Step
  ////////////////////

  // Invariants: x*b == a*u and y*b == a*v (mod m)
  always_ff @(posedge CLK) begin
    case (state)
      S_IDLE: begin
        if (start) begin
          m_reg           <= job.modulus;
          u               <= job.divisor;
          v               <= job.modulus;
          x               <= job.dividend;
          y               <= ZERO_DATA;
          result.tag      <= job.tag;
          result.quotient <= ZERO_DATA;
          if (bad_m) begin
            result.status <= bad_modulus;
          end else if (bad_op) begin
            result.status <= bad_operand;
          end else begin
            result.status <= ok;
          end
        end
      end
      S_RUN: begin
        if (u == ONE_DATA) begin
          result.quotient <= x;
        end else if (v == ONE_DATA) begin
          result.quotient <= y;
        end else if ((u == ZERO_DATA) || (v == ZERO_DATA)) begin
          // Quotient stays zero
          result.status <= no_inverse;
        end else if (!u[0]) begin
          u <= u >> 1;
          x <= x_half;
        end else if (!v[0]) begin
          v <= v >> 1;
          y <= y_half;
        end else if (u >= v) begin
          u <= u - v;
          x <= x_diff;
        end else begin
          v <= v - u;
          y <= y_diff;
        end
      end
      default: begin
      end
    endcase
  end

endmodule

/* hw/ntm_divider_dispatch.sv */
/*
 * Job dispatcher
 * Four-phase req/ack on the job port
 * One-hot start to the lowest-numbered idle lane
 */

`timescale 1ns/1ns

module ntm_divider_dispatch
  import ntm_divider_pkg::*;
(
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 job_req,
  input  div_job_t             job,
  input  logic [NUM_LANES-1:0] lane_idle,
  output logic                 job_ack,
  output logic [NUM_LANES-1:0] lane_start,
  output div_job_t             lane_job
);

  ////////////////////
  // Lane choice
  ////////////////////

  logic [NUM_LANES-1:0] free_lanes;
  logic [NUM_LANES-1:0] pick;
  logic                 accept;

  // A lane being started this cycle is not yet seen as busy
  assign free_lanes = lane_idle & ~lane_start;

  // Lowest set bit
  assign pick = free_lanes & (~free_lanes + 1'b1);

  // New request, previous ack gone, some lane free
  assign accept = job_req && !job_ack && (|free_lanes);

  ////////////////////
  // Handshake
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      job_ack    <= 1'b0;
      lane_start <= '0;
    end else begin
      // Start is a single-cycle pulse
      lane_start <= '0;
      if (accept) begin
        lane_start <= pick;
        job_ack    <= 1'b1;
      end else if (!job_req) begin
        job_ack <= 1'b0;
      end
    end
  end

  // Job onto the shared lane bus
  always_ff @(posedge CLK) begin
    if (accept) begin
      lane_job <= job;
    end
  end

endmodule

/* hw/ntm_divider_collect.sv */
/*
 * Result collector
 * Round-robin choice over the finished lanes
 * Four-phase req/ack on the result port
 */

`timescale 1ns/1ns

module ntm_divider_collect
  import ntm_divider_pkg::*;
(
  input  logic                              CLK,
  input  logic                              RST,
  input  logic [NUM_LANES-1:0]              lane_done,
  input  div_result_t [NUM_LANES-1:0]       lane_result,
  input  logic                              res_ack,
  output logic [NUM_LANES-1:0]              lane_take,
  output logic                              res_req,
  output div_result_t                       res
);

  ////////////////////
  // Round robin
  ////////////////////

  logic [LANE_SIZE-1:0] last;
  logic [LANE_SIZE-1:0] idx;
  logic [LANE_SIZE-1:0] sel;
  logic                 found;
  logic                 busy;
  logic                 grab;

  // Search starts right after the last lane served
  always_comb begin
    found = 1'b0;
    sel   = last;
    idx   = last;
    for (int k = 1; k <= NUM_LANES; k++) begin
      // Wraps on its own, lane count is a power of two
      idx = last + LANE_SIZE'(k);
      if (!found && lane_done[idx]) begin
        found = 1'b1;
        sel   = idx;
      end
    end
  end

  assign grab = !busy && found;

  ////////////////////
  // Handshake
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy      <= 1'b0;
      res_req   <= 1'b0;
      lane_take <= '0;
      last      <= '0;
    end else begin
      lane_take <= '0;
      if (grab) begin
        busy           <= 1'b1;
        res_req        <= 1'b1;
        lane_take[sel] <= 1'b1;
        last           <= sel;
      end else if (res_req && res_ack) begin
        res_req <= 1'b0;
      end else if (busy && !res_req && !res_ack) begin
        // Four-phase cycle complete
        busy <= 1'b0;
      end
    end
  end

  // Result held stable while res_req is high
  always_ff @(posedge CLK) begin
    if (grab) begin
      res <= lane_result[sel];
    end
  end

endmodule

/* hw/ntm_vector_modular_divider.sv */
/*
 * Vector modular divider top level
 * Dispatcher, NUM_LANES scalar lanes, collector
 */

`timescale 1ns/1ns

module ntm_vector_modular_divider
  import ntm_divider_pkg::*;
(
  input  logic        CLK,
  input  logic        RST,
  input  logic        job_req,
  output logic        job_ack,
  input  div_job_t    job,
  output logic        res_req,
  input  logic        res_ack,
  output div_result_t res
);

  ////////////////////
  // Lane buses
  ////////////////////

  logic [NUM_LANES-1:0]        lane_idle;
  logic [NUM_LANES-1:0]        lane_start;
  logic [NUM_LANES-1:0]        lane_done;
  logic [NUM_LANES-1:0]        lane_take;
  div_job_t                    lane_job;
  div_result_t [NUM_LANES-1:0] lane_result;

  // Input side
  ntm_divider_dispatch dispatch0 (
    .CLK        (CLK),
    .RST        (RST),
    .job_req    (job_req),
    .job        (job),
    .lane_idle  (lane_idle),
    .job_ack    (job_ack),
    .lane_start (lane_start),
    .lane_job   (lane_job)
  );

  // Lanes share the job bus, start selects one
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    ntm_scalar_modular_divider lane (
      .CLK    (CLK),
      .RST    (RST),
      .start  (lane_start[i]),
      .job    (lane_job),
      .take   (lane_take[i]),
      .idle   (lane_idle[i]),
      .done   (lane_done[i]),
      .result (lane_result[i])
    );
  end

  // Output side
  ntm_divider_collect collect0 (
    .CLK         (CLK),
    .RST         (RST),
    .lane_done   (lane_done),
    .lane_result (lane_result),
    .res_ack     (res_ack),
    .lane_take   (lane_take),
    .res_req     (res_req),
    .res         (res)
  );

endmodule

/* tests/ntm_divider_clock.sv */
/*
 * Testbench clock and reset
 * CLK with a 10 ns period, RST high for the first 10 cycles
 */

`timescale 1ns/1ns

module ntm_divider_clock (
  output logic CLK,
  output logic RST
);

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  // Released on the 10th rising edge
  initial begin
    RST = 1'b1;
    repeat (10) @(posedge CLK);
    RST <= 1'b0;
  end

endmodule

/* tests/ntm_divider_checker.sv */
/*
 * Checker for the vector modular divider
 * Models each accepted job and matches results by tag
 * Prints the closing line with the error counts
 */

`timescale 1ns/1ns

module ntm_divider_checker
  import ntm_divider_pkg::*;
(
  input  logic        CLK,
  input  logic        RST,
  input  logic        job_req,
  input  logic        job_ack,
  input  div_job_t    job,
  input  logic        res_req,
  input  div_result_t res,
  input  logic        end_run,
  input  int          assert_fails,
  input  int          timeouts,
  output int          error_count,
  output int          outstanding
);

  localparam int NUM_TAGS = 1 << TAG_SIZE;

  // Outstanding jobs indexed by tag
  div_job_t    jobs     [NUM_TAGS];
  div_result_t expected [NUM_TAGS];
  logic        pending  [NUM_TAGS];

  logic ack_q;
  logic req_q;
  int   req_wait;
  int   stalls;
  int   mismatches;
  int   tag_errors;
  int   coverage_misses;

  ////////////////////
  // Reference model
  ////////////////////

  // Status rules and then the inverse of b by extended Euclid
  function automatic div_result_t model_result(div_job_t j);
    div_result_t r;
    longint      r0;
    longint      r1;
    longint      t0;
    longint      t1;
    longint      q;
    longint      tmp;
    logic [63:0] prod;
    r.tag      = j.tag;
    r.quotient = '0;
    r.status   = ok;
    if (!j.modulus[0] || j.modulus < 3) begin
      r.status = bad_modulus;
    end else if (j.dividend >= j.modulus || j.divisor >= j.modulus) begin
      r.status = bad_operand;
    end else begin
      r0 = longint'(j.modulus);
      r1 = longint'(j.divisor);
      t0 = 0;
      t1 = 1;
      while (r1 != 0) begin
        q   = r0 / r1;
        tmp = r0 - q * r1;
        r0  = r1;
        r1  = tmp;
        tmp = t0 - q * t1;
        t0  = t1;
        t1  = tmp;
      end
      // gcd left in r0
      if (r0 != 1) begin
        r.status = no_inverse;
      end else begin
        if (t0 < 0) begin
          t0 = t0 + longint'(j.modulus);
        end
        prod       = 64'(j.dividend) * 64'(t0);
        r.quotient = DATA_SIZE'(prod % 64'(j.modulus));
      end
    end
    return r;
  endfunction

  ////////////////////
  // Comparison
  ////////////////////

  task automatic compare_result();
    div_result_t e;
    div_job_t    j;
    logic [63:0] check;
    if (!pending[res.tag]) begin
      $display("result arrived with an unknown or duplicate tag %0h", res.tag);
      tag_errors++;
    end else begin
      e = expected[res.tag];
      j = jobs[res.tag];
      pending[res.tag] = 1'b0;
      outstanding--;
      if (res.status != e.status) begin
        $display("mismatch res.status tag %0h: got %h, expected %h",
                 res.tag, res.status, e.status);
        mismatches++;
      end
      if (res.quotient != e.quotient) begin
        $display("mismatch res.quotient tag %0h: got %h, expected %h",
                 res.tag, res.quotient, e.quotient);
        mismatches++;
      end
      // q*b must give back a
      if (e.status == ok && res.status == ok) begin
        check = (64'(res.quotient) * 64'(j.divisor)) % 64'(j.modulus);
        if (check != 64'(j.dividend)) begin
          $display("mismatch res.quotient*b mod m tag %0h: got %h, expected %h",
                   res.tag, check, j.dividend);
          mismatches++;
        end
      end
    end
  endtask

  initial begin
    for (int i = 0; i < NUM_TAGS; i++) begin
      pending[i] = 1'b0;
    end
    ack_q           = 1'b0;
    req_q           = 1'b0;
    req_wait        = 0;
    stalls          = 0;
    mismatches      = 0;
    tag_errors      = 0;
    coverage_misses = 0;
    error_count     = 0;
    outstanding     = 0;
  end

  // Values seen here are the ones before the edge
  always @(posedge CLK) begin
    if (!RST) begin
      // Job is still held when job_ack rises
      if (job_ack && !ack_q) begin
        if (pending[job.tag]) begin
          $display("tag %0h was sent again before its result came back", job.tag);
          tag_errors++;
        end else begin
          outstanding++;
        end
        jobs[job.tag]     = job;
        expected[job.tag] = model_result(job);
        pending[job.tag]  = 1'b1;
      end
      if (res_req && !req_q) begin
        compare_result();
      end
      // A request left waiting past one cycle means every lane was busy
      if (job_req && !job_ack) begin
        req_wait++;
        if (req_wait == 2) begin
          stalls++;
        end
      end else begin
        req_wait = 0;
      end
      ack_q = job_ack;
      req_q = res_req;
    end
  end

  ////////////////////
  // End of run
  ////////////////////

  always @(posedge end_run) begin
    for (int i = 0; i < NUM_TAGS; i++) begin
      if (pending[i]) begin
        $display("tag %0h was sent but its result never came back", i);
        tag_errors++;
      end
    end
    if (stalls == 0) begin
      $display("job_ack was never withheld because the lanes never all filled");
      coverage_misses++;
    end
    error_count = mismatches + tag_errors + coverage_misses + assert_fails + timeouts;
    $display("errors %0d: mismatch %0d, tag %0d, coverage %0d, assert %0d, timeout %0d",
             error_count, mismatches, tag_errors, coverage_misses, assert_fails, timeouts);
  end

endmodule

/* tests/ntm_divider_asserts.sv */
/*
 * Four-phase handshake assertions
 * Bound to the vector modular divider top level
 */

`timescale 1ns/1ns

module ntm_divider_asserts
  import ntm_divider_pkg::*;
(
  input logic        CLK,
  input logic        RST,
  input logic        job_req,
  input logic        job_ack,
  input logic        res_req,
  input logic        res_ack,
  input div_result_t res
);

  // Failures seen so far
  int fail_count = 0;

  // Ack only answers a request
  ack_follows_req: assert property (@(posedge CLK) disable iff (RST)
    $rose(job_ack) |-> $past(job_req))
  else begin
    $error("job_ack rose while job_req was low");
    fail_count++;
  end

  // Result frozen for the whole request
  res_held: assert property (@(posedge CLK) disable iff (RST)
    (res_req && $past(res_req)) |-> $stable(res))
  else begin
    $error("res changed while res_req was high");
    fail_count++;
  end

  // Previous cycle must be fully closed
  req_after_ack_low: assert property (@(posedge CLK) disable iff (RST)
    $rose(res_req) |-> !$past(res_ack))
  else begin
    $error("res_req rose while res_ack was still high");
    fail_count++;
  end

endmodule

/* tests/ntm_divider_tb.sv */
/*
 * Testbench top for the vector modular divider
 * Random jobs over the job port and delayed res_ack on the result port
 * Clock, DUT, checker and bound assertions
 */

`timescale 1ns/1ns

module ntm_divider_tb
  import ntm_divider_pkg::*;
();

  localparam int NUM_JOBS   = 200;
  localparam int WAIT_LIMIT = 1000;

  logic        CLK;
  logic        RST;
  logic        job_req;
  logic        job_ack;
  logic        res_req;
  logic        res_ack;
  div_job_t    job;
  div_result_t res;
  logic        end_run;
  int          timeouts;
  int          error_count;
  int          outstanding;
  int          assert_fails;

  ntm_divider_clock clock0 (
    .CLK (CLK),
    .RST (RST)
  );

  ntm_vector_modular_divider dut0 (
    .CLK     (CLK),
    .RST     (RST),
    .job_req (job_req),
    .job_ack (job_ack),
    .job     (job),
    .res_req (res_req),
    .res_ack (res_ack),
    .res     (res)
  );

  ntm_divider_checker checker0 (
    .CLK          (CLK),
    .RST          (RST),
    .job_req      (job_req),
    .job_ack      (job_ack),
    .job          (job),
    .res_req      (res_req),
    .res          (res),
    .end_run      (end_run),
    .assert_fails (assert_fails),
    .timeouts     (timeouts),
    .error_count  (error_count),
    .outstanding  (outstanding)
  );

  // Handshake rules on both ports
  bind ntm_vector_modular_divider ntm_divider_asserts asserts0 (
    .CLK     (CLK),
    .RST     (RST),
    .job_req (job_req),
    .job_ack (job_ack),
    .res_req (res_req),
    .res_ack (res_ack),
    .res     (res)
  );

  assign assert_fails = dut0.asserts0.fail_count;

  ////////////////////
  // Stimulus helpers
  ////////////////////

  // Inputs change 1 ns after the edge
  task automatic next_cycle();
    @(posedge CLK);
    #1;
  endtask

  // Mix of valid jobs, shared factors, bad moduli, bad operands and edge divisors
  function automatic div_job_t make_job(logic [TAG_SIZE-1:0] tag);
    div_job_t j;
    int       kind;
    logic [DATA_SIZE-1:0] m;
    logic [DATA_SIZE-1:0] p;
    kind       = $urandom_range(0, 9);
    j.tag      = tag;
    m          = $urandom | 1;
    if (m < 3) begin
      m = 3;
    end
    j.modulus  = m;
    j.dividend = $urandom % m;
    j.divisor  = $urandom % m;
    case (kind)
      5: begin
        // Small odd modulus where gcd is often not 1
        m          = $urandom_range(3, 99) | 1;
        j.modulus  = m;
        j.dividend = $urandom % m;
        j.divisor  = $urandom % m;
      end
      6: begin
        p          = 3 + 2 * $urandom_range(0, 2);
        m          = p * ($urandom_range(1, 1 << 20) | 1);
        j.modulus  = m;
        j.dividend = $urandom % m;
        j.divisor  = p * ($urandom % (m / p));
        if ($urandom_range(0, 3) == 0) begin
          j.divisor = '0;
        end
      end
      7: begin
        // Even modulus or one of 0 to 2
        if ($urandom_range(0, 1) == 0) begin
          j.modulus = $urandom & ~32'd1;
        end else begin
          j.modulus = $urandom_range(0, 2);
        end
        j.dividend = $urandom;
        j.divisor  = $urandom;
      end
      8: begin
        m          = ($urandom >> 1) | 1;
        if (m < 3) begin
          m = 3;
        end
        j.modulus  = m;
        j.dividend = $urandom % m;
        j.divisor  = $urandom % m;
        if ($urandom_range(0, 1) == 0) begin
          j.dividend = m + ($urandom >> 1);
        end else begin
          j.divisor = m + ($urandom >> 1);
        end
      end
      9: begin
        j.divisor = ($urandom_range(0, 1) == 0) ? ONE_DATA : (m - 1);
      end
      default: begin
      end
    endcase
    return j;
  endfunction

  // Full four-phase cycle on the job port
  task automatic send_job(input int n);
    div_job_t j;
    int       count;
    j       = make_job(n[TAG_SIZE-1:0]);
    job     = j;
    job_req = 1'b1;
    count   = 0;
    while (!job_ack && count < WAIT_LIMIT) begin
      next_cycle();
      count++;
    end
    if (!job_ack) begin
      $display("timeout: job_ack never rose for job %0d", n);
      timeouts++;
    end
    job_req = 1'b0;
    count   = 0;
    // Job held until the ack is gone
    while (job_ack && count < WAIT_LIMIT) begin
      next_cycle();
      count++;
    end
    if (job_ack) begin
      $display("timeout: job_ack never fell for job %0d", n);
      timeouts++;
    end
  endtask

  ////////////////////
  // Result sink
  ////////////////////

  initial begin : sink
    int count;
    int delay;
    res_ack = 1'b0;
    count   = 0;
    while (RST && count < WAIT_LIMIT) begin
      next_cycle();
      count++;
    end
    while (!end_run && timeouts == 0) begin
      count = 0;
      while (!res_req && !end_run && count < WAIT_LIMIT) begin
        next_cycle();
        count++;
      end
      if (res_req) begin
        // Random back-pressure of 0 to 5 cycles
        delay = $urandom_range(0, 5);
        repeat (delay) next_cycle();
        res_ack = 1'b1;
        count   = 0;
        while (res_req && count < WAIT_LIMIT) begin
          next_cycle();
          count++;
        end
        if (res_req) begin
          $display("timeout: res_req stayed high after res_ack");
          timeouts++;
        end
        res_ack = 1'b0;
      end else if (!end_run) begin
        $display("timeout: no result arrived on the result port");
        timeouts++;
      end
    end
  end

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin : main
    int count;
    void'($urandom(90));
    job_req    = 1'b0;
    job        = '0;
    end_run    = 1'b0;
    timeouts   = 0;
    count      = 0;
    while (RST && count < WAIT_LIMIT) begin
      next_cycle();
      count++;
    end
    for (int n = 0; n < NUM_JOBS && timeouts == 0; n++) begin
      send_job(n);
    end
    // Drain every result still in flight
    count = 0;
    while ((outstanding != 0 || res_req || res_ack) && count < WAIT_LIMIT) begin
      next_cycle();
      count++;
    end
    if (outstanding != 0 || res_req || res_ack) begin
      $display("timeout: results still outstanding at the end of the run");
      timeouts++;
    end
    end_run = 1'b1;
    #1;
    if (error_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* ntm_vector_modular_divider.f */
hw/ntm_divider_pkg.sv
hw/ntm_scalar_modular_divider.sv
hw/ntm_divider_dispatch.sv
hw/ntm_divider_collect.sv
hw/ntm_vector_modular_divider.sv
tests/ntm_divider_clock.sv
tests/ntm_divider_checker.sv
tests/ntm_divider_asserts.sv
tests/ntm_divider_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the vector modular divider testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module ntm_divider_tb \
  -f ntm_vector_modular_divider.f \
  -Mdir obj_dir \
  -o ntm_divider_sim

# Keep running past the first assertion so the testbench can report
./obj_dir/ntm_divider_sim +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
  exit 0
else
  exit 1
fi
